/* tests/pmcc_tests.txt */
// Per case: program word count and trace length in hex, the program words
// from address 0, then the expected pc trace up to HALT. 0 0 ends the list.

// Mixed NOP lengths, skipped words hold HALT opcodes.
b 5
00400000 03000000 00000000 00800000 03000000 03000000
00c00000 03000000 03000000 03000000 03000000
0 2 3 6 a
// Single loop of 3.
4 8
01000300 00000000 02000000 03000000
0 1 2 1 2 1 2 3
// Loop with count 0 is ignored.
4 4
01000000 00000000 02000000 03000000
0 1 2 3
// Outer loop of 2 with one extra word, inner loop of 3.
7 12
01400200 03000000 01000300 00000000 02000000 02000000 03000000
0 2 3 4 3 4 3 4 5 2 3 4 3 4 3 4 5 6
// Three levels of 2, second inner loop right after a branch.
9 22
01000200 01000200 01000200 02000000 01000200 02000000 02000000 02000000 03000000
0 1 2 3 3 4 5 5 6 2 3 3 4 5 5 6 7 1 2 3 3 4 5 5 6 2 3 3 4 5 5 6 7 8
0 0

/* pmcc_sequencer.f */
logic/pmcc_isa_pkg.sv
logic/pmcc_core_pkg.sv
logic/pmcc_fetch.sv
logic/pmcc_loop_lifo.sv
logic/pmcc_loop_controller.sv
logic/pmcc_sequencer.sv
tests/pmcc_trace_checker.sv
tests/pmcc_sequencer_props.sv
tests/pmcc_sequencer_tb.sv

/* Makefile */
# Verilator build and run of the pmcc sequencer testbench.

VERILATOR ?= verilator
TOP       ?= pmcc_sequencer_tb
FILELIST  ?= pmcc_sequencer.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes.
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS) | tee $(LOG)
	grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/pmcc_sequencer_tb.sv */
`timescale 1ns/100ps
`default_nettype none

// ################################################
// pmcc sequencer testbench
// Loads each program from the case file, runs it
// twice and checks the retired pc trace.
// ################################################

module pmcc_sequencer_tb import pmcc_isa_pkg::*, pmcc_core_pkg::*; ();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 16;
    localparam int WORDS_MAX    = 256;
    localparam int RUN_LIMIT    = 200;  // Cycles per run.

    logic        clk;
    logic        rst_n;
    logic        start;
    logic        prog_we;
    pmcc_addr_t  prog_addr;
    pmcc_instr_t prog_wdata;
    pmcc_addr_t  pc;
    logic        pc_valid;
    logic        done;
    logic [31:0] test_words [WORDS_MAX];

    pmcc_sequencer i_pmcc_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_wdata (prog_wdata),
        .pc         (pc),
        .pc_valid   (pc_valid),
        .done       (done)
    );

    pmcc_trace_checker i_trace_checker (
        .clk      (clk),
        .rst_n    (rst_n),
        .pc       (pc),
        .pc_valid (pc_valid),
        .done     (done)
    );

    bind pmcc_loop_controller pmcc_sequencer_props i_sequencer_props (
        .clk         (clk),
        .rst_n       (rst_n),
        .loop        (loop),
        .branch      (branch),
        .branch_exec (branch_exec),
        .push        (lifo_push),
        .full        (lifo_full)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic load_program(input int first, input int count);
        for (int a = 0; a < count; a++) begin
            @(negedge clk);
            prog_we    = 1'b1;
            prog_addr  = pmcc_addr_t'(a);
            prog_wdata = test_words[first + a];
        end
        @(negedge clk);
        prog_we = 1'b0;
    endtask

    task automatic pulse_start();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    // ################################################
    // Case loop and verdict
    // ################################################

    initial begin
        int idx;
        int n_prog;
        int n_trace;
        int n_cases;
        int setup_errors;
        int assert_fails;
        rst_n        = 1'b0;
        start        = 1'b0;
        prog_we      = 1'b0;
        prog_addr    = '0;
        prog_wdata   = '0;
        idx          = 0;
        n_cases      = 0;
        setup_errors = 0;
        $readmemh("tests/pmcc_tests.txt", test_words);
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        // Header holds program length and trace length.
        while (idx < WORDS_MAX - 2 && test_words[idx] != 32'h0) begin
            n_prog  = int'(test_words[idx]);
            n_trace = int'(test_words[idx + 1]);
            load_program(idx + 2, n_prog);
            for (int run = 0; run < 2; run++) begin  // Second run follows done.
                for (int k = 0; k < n_trace; k++) begin
                    i_trace_checker.expect_pc(test_words[idx + 2 + n_prog + k][ADDR_W-1:0]);
                end
                pulse_start();
                i_trace_checker.wait_done(RUN_LIMIT);
            end
            idx = idx + 2 + n_prog + n_trace;
            n_cases++;
        end
        if (n_cases == 0) begin
            setup_errors++;
            $display("No test cases were read from tests/pmcc_tests.txt");
        end

        assert_fails = i_pmcc_sequencer.u_loop_controller.i_sequencer_props.fail_count;
        $display("Cases %0d, pcs checked %0d, errors %0d, assertion failures %0d",
                 n_cases, i_trace_checker.check_count,
                 i_trace_checker.error_count + setup_errors, assert_fails);
        if (i_trace_checker.error_count + setup_errors + assert_fails == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/pmcc_sequencer_props.sv */
`timescale 1ns/100ps
`default_nettype none

// ################################################
// pmcc loop controller properties
// Strobe exclusivity, stack overflow, branch cause.
// ################################################

module pmcc_sequencer_props (
    input  logic clk,
    input  logic rst_n,
    input  logic loop,
    input  logic branch,
    input  logic branch_exec,
    input  logic push,
    input  logic full
);

    int fail_count = 0;

    a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n) !(loop && branch))
        else begin
            fail_count++;
            $error("loop and branch strobes high in the same cycle");
        end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) !(push && full))
        else begin
            fail_count++;
            $error("loop context pushed while the stack is full");
        end

    a_branch_cause: assert property (@(posedge clk) disable iff (!rst_n) branch_exec |-> branch)
        else begin
            fail_count++;
            $error("branch_exec high without a branch strobe");
        end

endmodule

`default_nettype wire

/* tests/pmcc_trace_checker.sv */
`timescale 1ns/100ps
`default_nettype none

// ################################################
// pmcc trace checker
// Compares each retired pc with the expected
// trace and checks when done rises and falls.
// ################################################

module pmcc_trace_checker import pmcc_core_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  pmcc_addr_t pc,
    input  logic       pc_valid,
    input  logic       done
);

    pmcc_addr_t exp_q [$];     // Expected pcs, oldest first.
    pmcc_addr_t exp_pc;
    logic       last_retired = 1'b0;  // Final expected pc retired last cycle.
    logic       done_prev    = 1'b0;
    int         error_count = 0;
    int         check_count = 0;

    // Outputs only move on the rising edge.
    always @(negedge clk) begin
        if (rst_n) begin
            if (last_retired && done !== 1'b1) begin
                error_count++;
                $display("[ERROR] done: expected 1, got %h after the HALT", done);
            end
            // A new run drops done and raises pc_valid together.
            if (done_prev && !done && !pc_valid) begin
                error_count++;
                $display("done fell before the next run started");
            end
            last_retired = 1'b0;
            done_prev    = done;
            if (pc_valid) begin
                if (exp_q.size() == 0) begin
                    error_count++;
                    $display("Retired pc %h with no expected address left", pc);
                end else begin
                    exp_pc = exp_q.pop_front();
                    check_count++;
                    if (pc !== exp_pc) begin
                        error_count++;
                        $display("[ERROR] pc: expected %h, got %h", exp_pc, pc);
                    end
                    last_retired = (exp_q.size() == 0);
                end
            end
        end
    end

    task automatic expect_pc(input pmcc_addr_t addr);
        exp_q.push_back(addr);
    endtask

    // Waits for done, then checks that the whole trace was retired.
    task automatic wait_done(input int limit);
        int cycles;
        cycles = 0;
        while (!done && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            error_count++;
            $display("done did not rise within %0d cycles", limit);
        end
        if (exp_q.size() != 0) begin
            error_count++;
            $display("%0d expected pcs were never retired", exp_q.size());
            exp_q.delete();
        end
    endtask

endmodule

`default_nettype wire

/* logic/pmcc_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

// ################################################
// pmcc sequencer top level
// Fetch stage with its loop controller.
// ################################################

module pmcc_sequencer import pmcc_isa_pkg::*, pmcc_core_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  logic        prog_we,
    input  pmcc_addr_t  prog_addr,
    input  pmcc_instr_t prog_wdata,
    output pmcc_addr_t  pc,
    output logic        pc_valid,
    output logic        done
);

    pmcc_instr_t instr;
    pmcc_size_t  instr_size;
    pmcc_addr_t  branch_dst;
    logic        loop;
    logic        branch;
    logic        branch_exec;

    pmcc_fetch u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .prog_we     (prog_we),
        .prog_addr   (prog_addr),
        .prog_wdata  (prog_wdata),
        .branch_exec (branch_exec),
        .branch_dst  (branch_dst),
        .pc          (pc),
        .pc_valid    (pc_valid),
        .instr       (instr),
        .instr_size  (instr_size),
        .loop        (loop),
        .branch      (branch),
        .done        (done)
    );

    pmcc_loop_controller u_loop_controller (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .loop        (loop),
        .branch      (branch),
        .instr       (instr),
        .instr_size  (instr_size),
        .pc          (pc),
        .branch_exec (branch_exec),
        .branch_dst  (branch_dst)
    );

endmodule

`default_nettype wire

/* logic/pmcc_loop_controller.sv */
`timescale 1ns/100ps
`default_nettype none

// ################################################
// pmcc loop controller
// Tracks nested counted loops and requests
// jumps back to the loop start from fetch.
// ################################################

module pmcc_loop_controller import pmcc_isa_pkg::*, pmcc_core_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  logic        loop,
    input  logic        branch,
    input  pmcc_instr_t instr,
    input  pmcc_size_t  instr_size,
    input  pmcc_addr_t  pc,
    output logic        branch_exec,
    output pmcc_addr_t  branch_dst
);

    pmcc_loop_t active_loop, active_loop_nxt;
    pmcc_loop_t cur_loop;      // Context in force this cycle.
    pmcc_loop_t lifo_wdata, lifo_rdata;
    logic       loop_execution, loop_execution_nxt;
    logic       lifo_readout, lifo_readout_nxt;
    logic       lifo_push, lifo_pop, lifo_full, lifo_empty;
    pmcc_iter_t iterations;
    pmcc_iter_t cur_iter;
    pmcc_addr_t cur_start;
    pmcc_addr_t body_start;

    assign iterations = {instr[ITER_HI_MSB:ITER_HI_LSB], instr[ITER_LO_MSB:ITER_LO_LSB]};
    assign body_start = pc + pmcc_addr_t'(instr_size) + 1'b1;  // Word after the LOOP.

    // A context popped last cycle takes over from the registers.
    assign cur_loop  = lifo_readout ? lifo_rdata : active_loop;
    assign cur_iter  = cur_loop[LOOP_ITER_MSB:LOOP_ITER_LSB];
    assign cur_start = cur_loop[LOOP_START_MSB:LOOP_START_LSB];

    pmcc_loop_lifo u_loop_lifo (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (start),
        .push  (lifo_push),
        .pop   (lifo_pop),
        .wdata (lifo_wdata),
        .rdata (lifo_rdata),
        .full  (lifo_full),
        .empty (lifo_empty)
    );

    // ################################################
    // Loop rules
    // ################################################

    always_comb begin
        branch_exec        = 1'b0;
        branch_dst         = '0;
        active_loop_nxt    = cur_loop;
        loop_execution_nxt = loop_execution;
        lifo_readout_nxt   = 1'b0;
        lifo_push          = 1'b0;
        lifo_pop           = 1'b0;
        lifo_wdata         = cur_loop;

        if (loop) begin
            if (iterations != '0) begin  // Zero count is ignored.
                active_loop_nxt = {body_start, pmcc_iter_t'(iterations - 1'b1)};
                if (loop_execution) begin
                    lifo_push = 1'b1;  // Suspend the outer loop.
                end else begin
                    loop_execution_nxt = 1'b1;
                end
            end
        end else if (branch && loop_execution) begin
            if (cur_iter != '0) begin
                branch_exec = 1'b1;
                branch_dst  = cur_start;
                active_loop_nxt[LOOP_ITER_MSB:LOOP_ITER_LSB] = cur_iter - 1'b1;
            end else if (!lifo_empty) begin
                lifo_pop         = 1'b1;  // Resume the outer loop.
                lifo_readout_nxt = 1'b1;
            end else begin
                loop_execution_nxt = 1'b0;  // Outermost loop done.
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_loop    <= '0;
            loop_execution <= 1'b0;
            lifo_readout   <= 1'b0;
        end else if (start) begin
            active_loop    <= '0;
            loop_execution <= 1'b0;
            lifo_readout   <= 1'b0;
        end else begin
            active_loop    <= active_loop_nxt;
            loop_execution <= loop_execution_nxt;
            lifo_readout   <= lifo_readout_nxt;
        end
    end

endmodule

`default_nettype wire

/* logic/pmcc_loop_lifo.sv */
`timescale 1ns/100ps
`default_nettype none

// ################################################
// pmcc loop LIFO
// Stack of suspended outer loop contexts.
// ################################################

module pmcc_loop_lifo import pmcc_core_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       clear,
    input  logic       push,
    input  logic       pop,
    input  pmcc_loop_t wdata,
    output pmcc_loop_t rdata,
    output logic       full,
    output logic       empty
);

    pmcc_loop_t            stack_mem [LOOP_DEPTH];
    logic [LOOP_PTR_W-1:0] sp;       // Entries held.
    logic [LOOP_IDX_W-1:0] top_idx;
    logic                  do_push;
    logic                  do_pop;

    assign full    = (sp == LOOP_PTR_W'(LOOP_DEPTH));
    assign empty   = (sp == '0);
    assign top_idx = sp[LOOP_IDX_W-1:0] - 1'b1;
    assign do_push = push && !full && !clear;     // Extra push is dropped.
    assign do_pop  = pop && !empty && !clear && !do_push;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sp <= '0;
        end else if (clear) begin
            sp <= '0;
        end else if (do_push) begin
            sp <= sp + 1'b1;
        end else if (do_pop) begin
            sp <= sp - 1'b1;
        end
    end

    // Popped entry is seen on rdata one cycle later.
    always_ff @(posedge clk) begin
        if (do_push) begin
            stack_mem[sp[LOOP_IDX_W-1:0]] <= wdata;
        end
        if (do_pop) begin
            rdata <= stack_mem[top_idx];
        end
    end

endmodule

`default_nettype wire

/* logic/pmcc_fetch.sv */
`timescale 1ns/100ps
`default_nettype none

// ################################################
// pmcc fetch stage
// Program memory, program counter, decode and
// run control. One instruction per cycle.
// ################################################

module pmcc_fetch import pmcc_isa_pkg::*, pmcc_core_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start,
    input  logic        prog_we,
    input  pmcc_addr_t  prog_addr,
    input  pmcc_instr_t prog_wdata,
    input  logic        branch_exec,
    input  pmcc_addr_t  branch_dst,
    output pmcc_addr_t  pc,
    output logic        pc_valid,
    output pmcc_instr_t instr,
    output pmcc_size_t  instr_size,
    output logic        loop,
    output logic        branch,
    output logic        done
);

    typedef enum logic [1:0] {IDLE, RUN, HALTED} run_state_t;

    run_state_t  state;
    pmcc_instr_t prog_mem [PROG_DEPTH];
    logic [7:0]  opcode;
    logic        halt;

    // Loaded before start, read asynchronously at pc.
    always_ff @(posedge clk) begin
        if (prog_we) begin
            prog_mem[prog_addr] <= prog_wdata;
        end
    end

    assign instr      = prog_mem[pc];
    assign opcode     = instr[OPCODE_MSB:OPCODE_LSB];
    assign instr_size = instr[SIZE_MSB:SIZE_LSB];
    assign pc_valid   = (state == RUN);
    assign done       = (state == HALTED);

    always_comb begin
        loop   = 1'b0;
        branch = 1'b0;
        halt   = 1'b0;
        if (pc_valid) begin
            case (opcode)
                OP_LOOP:   loop   = 1'b1;
                OP_BRANCH: branch = 1'b1;
                OP_HALT:   halt   = 1'b1;
                OP_NOP:    ;  // Only the length counts.
                default:   ;
            endcase
        end
    end

    // ################################################
    // Run control and program counter
    // ################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            pc    <= '0;
        end else if (start) begin
            state <= RUN;  // Restart from address 0.
            pc    <= '0;
        end else if (state == RUN) begin
            if (halt) begin
                state <= HALTED;  // pc stays on the HALT.
            end else if (branch_exec) begin
                pc <= branch_dst;
            end else begin
                pc <= pc + pmcc_addr_t'(instr_size) + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/pmcc_core_pkg.sv */
`default_nettype none

// ################################################
// pmcc sequencer types
// Address, count and loop context widths.
// ################################################

package pmcc_core_pkg;

    localparam int ADDR_W     = 10;
    localparam int ITER_W     = 14;
    localparam int SIZE_W     = 2;
    localparam int PROG_DEPTH = 1 << ADDR_W;  // Program memory words.

    typedef logic [ADDR_W-1:0] pmcc_addr_t;
    typedef logic [ITER_W-1:0] pmcc_iter_t;
    typedef logic [SIZE_W-1:0] pmcc_size_t;

    // Loop context, start address above remaining count.
    localparam int LOOP_W         = ADDR_W + ITER_W;
    localparam int LOOP_ITER_LSB  = 0;
    localparam int LOOP_ITER_MSB  = ITER_W - 1;
    localparam int LOOP_START_LSB = ITER_W;
    localparam int LOOP_START_MSB = LOOP_W - 1;

    typedef logic [LOOP_W-1:0] pmcc_loop_t;

    localparam int LOOP_DEPTH = 8;
    localparam int LOOP_IDX_W = $clog2(LOOP_DEPTH);
    localparam int LOOP_PTR_W = LOOP_IDX_W + 1;  // Counts 0 to LOOP_DEPTH.

endpackage

`default_nettype wire

/* logic/pmcc_isa_pkg.sv */
`default_nettype none

// ################################################
// pmcc instruction set
// Opcode values and field positions of the
// 32-bit microcode instruction word.
// ################################################

package pmcc_isa_pkg;

    localparam int INSTR_W = 32;

    typedef logic [INSTR_W-1:0] pmcc_instr_t;

    // Opcode byte.
    localparam int OPCODE_MSB = 31;
    localparam int OPCODE_LSB = 24;

    localparam logic [7:0] OP_NOP    = 8'h00;
    localparam logic [7:0] OP_LOOP   = 8'h01;
    localparam logic [7:0] OP_BRANCH = 8'h02;
    localparam logic [7:0] OP_HALT   = 8'h03;

    localparam int SIZE_MSB = 23;  // Extra words after this one.
    localparam int SIZE_LSB = 22;

    // LOOP count is split over two fields, high part first.
    localparam int ITER_HI_MSB = 5;
    localparam int ITER_HI_LSB = 0;
    localparam int ITER_LO_MSB = 15;
    localparam int ITER_LO_LSB = 8;

endpackage

`default_nettype wire
